/* build.f */
rtl/axi_pkg.sv
rtl/adma_pkg.sv
rtl/adma_read_engine.sv
rtl/adma_write_engine.sv
rtl/adma_sequencer.sv
rtl/sd_adma_top.sv
tests/tb_clock_gen.sv
tests/tb_sd_adma.sv

/* Makefile */
VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing
TOP        ?= tb_sd_adma
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	@out=$$(./$(OBJ_DIR)/$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

/* tests/tb_sd_adma.sv */
`timescale 1ns/1ns

module tb_sd_adma
  import axi_pkg::*;
  import adma_pkg::*;
();

  logic       clock;
  logic       reset;
  logic       start;
  axi_addr_t  desc_pointer;
  logic       dir;
  logic       int_clear;
  logic       xfer_done;
  logic       card_word;
  axi_data_t  fifo_rd_data;
  logic       fifo_rd;
  logic       fifo_wr;
  axi_data_t  fifo_wr_data;
  logic [1:0] irq;
  axi_addr_t  araddr;
  axi_len_t   arlen;
  logic [2:0] arsize;
  logic [1:0] arburst;
  logic       arvalid;
  logic       arready;
  axi_data_t  rdata;
  axi_resp_t  rresp;
  logic       rlast;
  logic       rvalid;
  logic       rready;
  axi_addr_t  awaddr;
  axi_len_t   awlen;
  logic [2:0] awsize;
  logic [1:0] awburst;
  logic       awvalid;
  logic       awready;
  axi_data_t  wdata;
  logic       wlast;
  logic       wvalid;
  logic       wready;
  axi_resp_t  bresp;
  logic       bvalid;
  logic       bready;

  integer     seed;
  // Sparse system memory
  axi_data_t  mem [axi_addr_t];
  // Expected traffic, in order
  axi_addr_t  exp_ar [$];
  axi_addr_t  exp_aw [$];
  axi_data_t  exp_push [$];
  axi_addr_t  exp_waddr [$];
  axi_data_t  exp_wdata [$];
  // Bursts accepted by the memory model and still open
  axi_addr_t  rd_addr_q [$];
  axi_len_t   rd_len_q [$];
  axi_addr_t  wr_addr_q [$];
  axi_len_t   wr_len_q [$];
  int         r_idx;
  int         w_idx;
  int         b_pend;
  int         fifo_head;
  int         fifo_next;
  int         rerr_at;
  int         berr_at;
  logic       r_fired;
  logic       b_fired;
  logic       check_on;
  logic       card_on;

  tb_clock_gen u_clock_gen (
    .clock (clock),
    .reset (reset)
  );

  sd_adma_top uut (
    .clock (clock), .reset (reset), .start (start), .desc_pointer (desc_pointer),
    .dir (dir), .int_clear (int_clear), .xfer_done (xfer_done), .card_word (card_word),
    .fifo_rd_data (fifo_rd_data), .fifo_rd (fifo_rd), .fifo_wr (fifo_wr),
    .fifo_wr_data (fifo_wr_data), .irq (irq),
    .araddr (araddr), .arlen (arlen), .arsize (arsize), .arburst (arburst),
    .arvalid (arvalid), .arready (arready), .rdata (rdata), .rresp (rresp),
    .rlast (rlast), .rvalid (rvalid), .rready (rready),
    .awaddr (awaddr), .awlen (awlen), .awsize (awsize), .awburst (awburst),
    .awvalid (awvalid), .awready (awready), .wdata (wdata), .wlast (wlast),
    .wvalid (wvalid), .wready (wready), .bresp (bresp), .bvalid (bvalid),
    .bready (bready)
  );

  //////////////////////////////
  // Reporting and compares
  //////////////////////////////
  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input axi_data_t expected,
                            input axi_data_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s expected %h actual %h",
                               name, expected, actual));
    end
  endtask

  task automatic check_addr(input string name, input axi_addr_t expected,
                            input axi_addr_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s expected %h actual %h",
                               name, expected, actual));
    end
  endtask

  task automatic check_irq(input string name, input logic [1:0] expected,
                           input logic [1:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s expected %b actual %b",
                               name, expected, actual));
    end
  endtask

  // Size and burst type together
  task automatic check_attr(input string name, input logic [4:0] expected,
                            input logic [4:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s expected %b actual %b",
                               name, expected, actual));
    end
  endtask

  //////////////////////////////
  // Model helpers
  //////////////////////////////
  // True with a chance of quarters in four
  function automatic logic draw(input int quarters);
    int r;
    r = $random(seed);
    return (r & 3) < quarters;
  endfunction

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    r = r & 32'h7fff_ffff;
    return lo + r % (hi - lo + 1);
  endfunction

  // Untouched memory reads back a pattern of the full address
  function automatic axi_data_t mem_read(input axi_addr_t a);
    if (mem.exists(a)) begin
      return mem[a];
    end
    return (a * 32'h9e37_79b1) ^ 32'h3c5a_a5c3;
  endfunction

  // Word k of the card stream
  function automatic axi_data_t card_data(input int k);
    return 32'hc000_0000 ^ (axi_data_t'(k) * 32'h0001_0003);
  endfunction

  function automatic adma_desc_t make_desc(input logic valid, input logic last,
                                           input logic [1:0] act, input logic [15:0] len,
                                           input axi_addr_t addr);
    adma_desc_t d;
    d = '0;
    d[DESC_VALID] = valid;
    d[DESC_END] = last;
    d[DESC_ACT_LSB +: 2] = act;
    d[DESC_LEN_LSB +: 16] = len;
    d[DESC_ADDR_LSB +: 32] = addr;
    return d;
  endfunction

  // Store one line and queue the traffic it should cause
  task automatic add_desc(input axi_addr_t ptr, input logic valid, input logic last,
                          input logic [1:0] act, input int words, input axi_addr_t addr,
                          input logic c2m);
    adma_desc_t d;
    axi_addr_t  a;
    int         i;
    d = make_desc(valid, last, act, 16'(words * BYTES_PER_WORD), addr);
    mem[ptr] = d[31:0];
    mem[ptr + 32'd4] = d[63:32];
    exp_ar.push_back(ptr);
    if (valid && act == ACT_TRAN) begin
      for (i = 0; i < words; i++) begin
        a = addr + 32'(i * BYTES_PER_WORD);
        // New burst every 64 bytes
        if (i % MAX_BURST_BEATS == 0) begin
          if (c2m) begin
            exp_aw.push_back(a);
          end else begin
            exp_ar.push_back(a);
          end
        end
        if (c2m) begin
          exp_waddr.push_back(a);
          exp_wdata.push_back(card_data(fifo_next));
          fifo_next++;
        end else begin
          exp_push.push_back(mem_read(a));
        end
      end
    end
  endtask

  //////////////////////////////
  // Memory, FIFO and card model
  //////////////////////////////
  always @(negedge clock) begin : bus_model
    logic ar_fire;
    logic r_fire;
    logic aw_fire;
    logic w_fire;
    logic b_fire;
    arready = draw(3);
    awready = draw(3);
    wready = draw(3);
    card_word = card_on && draw(2);
    // A beat on offer is held until taken
    if (!(rvalid && !r_fired)) begin
      if (rd_addr_q.size() > 0 && draw(3)) begin
        rvalid = 1'b1;
        rdata = mem_read(rd_addr_q[0] + 32'(r_idx * BYTES_PER_WORD));
        rlast = (r_idx == int'(rd_len_q[0]));
        rresp = (rerr_at == 0) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        if (rerr_at >= 0) begin
          rerr_at--;
        end
      end else begin
        rvalid = 1'b0;
      end
    end
    if (!(bvalid && !b_fired)) begin
      if (b_pend > 0 && draw(2)) begin
        bvalid = 1'b1;
        bresp = (berr_at == 0) ? AXI_RESP_SLVERR : AXI_RESP_OKAY;
        if (berr_at >= 0) begin
          berr_at--;
        end
      end else begin
        bvalid = 1'b0;
      end
    end
    fifo_rd_data = card_data(fifo_head);
    #1;
    // Transfers that the next rising edge will complete
    ar_fire = arvalid && arready;
    r_fire = rvalid && rready;
    aw_fire = awvalid && awready;
    w_fire = wvalid && wready;
    b_fire = bvalid && bready;
    r_fired = r_fire;
    b_fired = b_fire;
    if (fifo_rd !== w_fire) begin
      report_failure("fifo_rd does not follow the accepted write beats");
    end
    if (ar_fire) begin
      // 4-byte beats, incrementing burst
      check_attr("ar size and burst", 5'b010_01, {arsize, arburst});
      if (check_on) begin
        if (exp_ar.size() == 0) begin
          report_failure("AR burst that no descriptor asks for");
        end else begin
          check_addr("ar burst address", exp_ar.pop_front(), araddr);
        end
      end
      rd_addr_q.push_back(araddr);
      rd_len_q.push_back(arlen);
    end
    if (r_fire) begin
      if (rlast) begin
        void'(rd_addr_q.pop_front());
        void'(rd_len_q.pop_front());
        r_idx = 0;
      end else begin
        r_idx++;
      end
    end
    if (aw_fire) begin
      check_attr("aw size and burst", 5'b010_01, {awsize, awburst});
      if (check_on) begin
        if (exp_aw.size() == 0) begin
          report_failure("AW burst that no descriptor asks for");
        end else begin
          check_addr("aw burst address", exp_aw.pop_front(), awaddr);
        end
      end
      wr_addr_q.push_back(awaddr);
      wr_len_q.push_back(awlen);
    end
    if (w_fire) begin
      if (wr_addr_q.size() == 0) begin
        report_failure("write beat without an open AW burst");
      end else if (wlast !== (w_idx == int'(wr_len_q[0]))) begin
        report_failure("wlast is not on the final beat of the write burst");
      end else begin
        mem[wr_addr_q[0] + 32'(w_idx * BYTES_PER_WORD)] = wdata;
        fifo_head++;
        if (w_idx == int'(wr_len_q[0])) begin
          void'(wr_addr_q.pop_front());
          void'(wr_len_q.pop_front());
          w_idx = 0;
          b_pend++;
        end else begin
          w_idx++;
        end
      end
    end
    if (b_fire) begin
      b_pend--;
    end
    if (fifo_wr && check_on) begin
      if (exp_push.size() == 0) begin
        report_failure("push into the card FIFO that no descriptor asks for");
      end else begin
        check_data("pushed word", exp_push.pop_front(), fifo_wr_data);
      end
    end
  end

  //////////////////////////////
  // Sequencing tasks
  //////////////////////////////
  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (!reset) begin
      @(negedge clock);
      cycles++;
      if (cycles > 100) begin
        report_failure("reset was never released");
      end
    end
  endtask

  task automatic wait_bus_quiet(input string what);
    int cycles;
    cycles = 0;
    while (exp_ar.size() != 0 || exp_aw.size() != 0 || exp_push.size() != 0 ||
           rd_addr_q.size() != 0 || wr_addr_q.size() != 0 || b_pend != 0) begin
      @(negedge clock);
      cycles++;
      if (cycles > 40000) begin
        report_failure({"timeout while waiting for the bus traffic of ", what});
      end
    end
  endtask

  task automatic wait_irq(input string what);
    int cycles;
    cycles = 0;
    while (irq == 2'b00) begin
      @(negedge clock);
      cycles++;
      if (cycles > 40000) begin
        report_failure({"timeout while waiting for an interrupt in ", what});
      end
    end
  endtask

  task automatic launch(input axi_addr_t ptr, input logic to_memory);
    @(negedge clock);
    start = 1'b1;
    desc_pointer = ptr;
    dir = to_memory;
    @(negedge clock);
    start = 1'b0;
  endtask

  task automatic expect_irq_quiet(input string name, input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      check_irq(name, 2'b00, irq);
    end
  endtask

  // Serializer done, then the transfer interrupt
  task automatic finish_transfer(input string name);
    expect_irq_quiet({name, " irq before xfer_done"}, 12);
    @(negedge clock);
    xfer_done = 1'b1;
    @(negedge clock);
    xfer_done = 1'b0;
    wait_irq(name);
    check_irq({name, " irq"}, 2'b01, irq);
  endtask

  task automatic clear_irq(input string name);
    @(negedge clock);
    int_clear = 1'b1;
    @(negedge clock);
    int_clear = 1'b0;
    check_irq({name, " irq after clear"}, 2'b00, irq);
  endtask

  //////////////////////////////
  // Test sequence
  //////////////////////////////
  initial begin : main
    int        i;
    int        n;
    axi_addr_t ptr;
    start = 1'b0;
    desc_pointer = '0;
    dir = 1'b0;
    int_clear = 1'b0;
    xfer_done = 1'b0;
    card_word = 1'b0;
    fifo_rd_data = '0;
    arready = 1'b0;
    rdata = '0;
    rresp = AXI_RESP_OKAY;
    rlast = 1'b0;
    rvalid = 1'b0;
    awready = 1'b0;
    wready = 1'b0;
    bresp = AXI_RESP_OKAY;
    bvalid = 1'b0;
    seed = 32'hb8a15bef;
    r_idx = 0;
    w_idx = 0;
    b_pend = 0;
    fifo_head = 0;
    fifo_next = 0;
    rerr_at = -1;
    berr_at = -1;
    r_fired = 1'b0;
    b_fired = 1'b0;
    check_on = 1'b1;
    card_on = 1'b0;
    wait_reset_release();

    // Idle after reset
    repeat (20) begin
      @(negedge clock);
      check_irq("idle", 2'b00, irq);
      if (arvalid || awvalid) begin
        report_failure("AXI request issued without a start pulse");
      end
    end

    // Card to memory chain
    ptr = 32'h0000_1000 + 32'(8 * rand_range(0, 31));
    n = rand_range(2, 4);
    for (i = 0; i < n; i++) begin
      add_desc(ptr + 32'(8 * i), 1'b1, (i == n - 1), ACT_TRAN, rand_range(1, 40),
               32'h0001_0000 + 32'(i * 32'h1000), 1'b1);
    end
    card_on = 1'b1;
    launch(ptr, 1'b1);
    wait_bus_quiet("card to memory");
    for (i = 0; i < exp_waddr.size(); i++) begin
      check_data("memory word", exp_wdata[i], mem_read(exp_waddr[i]));
    end
    exp_waddr.delete();
    exp_wdata.delete();
    finish_transfer("card to memory");
    clear_irq("card to memory");
    card_on = 1'b0;

    // Memory to card chain, tails included
    ptr = 32'h0000_2000 + 32'(8 * rand_range(0, 31));
    n = rand_range(2, 4);
    for (i = 0; i < n; i++) begin
      add_desc(ptr + 32'(8 * i), 1'b1, (i == n - 1), ACT_TRAN, rand_range(1, 50),
               32'h0004_0000 + 32'(i * 32'h1000), 1'b0);
    end
    launch(ptr, 1'b0);
    wait_bus_quiet("memory to card");
    finish_transfer("memory to card");
    clear_irq("memory to card");

    // Nop, link, tran, then nop with end
    ptr = 32'h0000_3000;
    add_desc(ptr, 1'b1, 1'b0, ACT_NOP, 0, 32'h0, 1'b0);
    add_desc(ptr + 32'd8, 1'b1, 1'b0, ACT_LINK, 0, 32'h0000_3800, 1'b0);
    add_desc(32'h0000_3800, 1'b1, 1'b0, ACT_TRAN, rand_range(17, 40),
             32'h0005_0000, 1'b0);
    add_desc(32'h0000_3808, 1'b1, 1'b1, ACT_NOP, 0, 32'h0, 1'b0);
    launch(ptr, 1'b0);
    wait_bus_quiet("descriptor walk");
    finish_transfer("descriptor walk");
    clear_irq("descriptor walk");

    // Line with valid clear
    add_desc(32'h0000_4000, 1'b0, 1'b1, ACT_TRAN, 8, 32'h0006_0000, 1'b0);
    launch(32'h0000_4000, 1'b0);
    wait_irq("invalid descriptor");
    check_irq("invalid descriptor irq", 2'b10, irq);
    clear_irq("invalid descriptor");
    wait_bus_quiet("invalid descriptor");

    // Error response on the first data beat
    check_on = 1'b0;
    add_desc(32'h0000_4100, 1'b1, 1'b1, ACT_TRAN, 24, 32'h0006_1000, 1'b0);
    exp_ar.delete();
    exp_push.delete();
    rerr_at = 2;
    launch(32'h0000_4100, 1'b0);
    wait_irq("read error");
    check_irq("read error irq", 2'b10, irq);
    clear_irq("read error");
    wait_bus_quiet("read error");

    // Error on the first write response
    add_desc(32'h0000_4200, 1'b1, 1'b1, ACT_TRAN, 20, 32'h0006_2000, 1'b1);
    exp_ar.delete();
    exp_aw.delete();
    exp_waddr.delete();
    exp_wdata.delete();
    berr_at = 0;
    card_on = 1'b1;
    launch(32'h0000_4200, 1'b1);
    wait_irq("write error");
    check_irq("write error irq", 2'b10, irq);
    clear_irq("write error");
    wait_bus_quiet("write error");
    card_on = 1'b0;

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  // 20 ns period
  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  // Reset low over the first two rising edges
  initial begin
    reset = 1'b0;
    repeat (2) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule

/* rtl/sd_adma_top.sv */
`timescale 1ns/1ns

module sd_adma_top
  import axi_pkg::*;
  import adma_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       start,
  input  axi_addr_t  desc_pointer,
  input  logic       dir,
  input  logic       int_clear,
  input  logic       xfer_done,
  input  logic       card_word,
  input  axi_data_t  fifo_rd_data,
  output logic       fifo_rd,
  output logic       fifo_wr,
  output axi_data_t  fifo_wr_data,
  output logic [1:0] irq,
  // AXI read side
  output axi_addr_t  araddr,
  output axi_len_t   arlen,
  output logic [2:0] arsize,
  output logic [1:0] arburst,
  output logic       arvalid,
  input  logic       arready,
  input  axi_data_t  rdata,
  input  axi_resp_t  rresp,
  input  logic       rlast,
  input  logic       rvalid,
  output logic       rready,
  // AXI write side
  output axi_addr_t  awaddr,
  output axi_len_t   awlen,
  output logic [2:0] awsize,
  output logic [1:0] awburst,
  output logic       awvalid,
  input  logic       awready,
  output axi_data_t  wdata,
  output logic       wlast,
  output logic       wvalid,
  input  logic       wready,
  input  axi_resp_t  bresp,
  input  logic       bvalid,
  output logic       bready
);

  logic        rd_go;
  axi_addr_t   rd_addr;
  word_count_t rd_words;
  logic        rd_to_fifo;
  logic        rd_busy;
  logic        rd_done;
  logic        rd_error;
  adma_desc_t  desc;
  logic        wr_go;
  axi_addr_t   wr_addr;
  word_count_t wr_words;
  logic        wr_done;
  logic        wr_error;

  // Word beats, incrementing bursts only
  assign arsize  = AXI_SIZE_WORD;
  assign awsize  = AXI_SIZE_WORD;
  assign arburst = AXI_BURST_INCR;
  assign awburst = AXI_BURST_INCR;

  adma_sequencer u_sequencer (
    .clock        (clock),
    .reset        (reset),
    .start        (start),
    .desc_pointer (desc_pointer),
    .dir          (dir),
    .int_clear    (int_clear),
    .xfer_done    (xfer_done),
    .rd_busy      (rd_busy),
    .rd_done      (rd_done),
    .rd_error     (rd_error),
    .desc         (desc),
    .wr_done      (wr_done),
    .wr_error     (wr_error),
    .rd_go        (rd_go),
    .rd_addr      (rd_addr),
    .rd_words     (rd_words),
    .rd_to_fifo   (rd_to_fifo),
    .wr_go        (wr_go),
    .wr_addr      (wr_addr),
    .wr_words     (wr_words),
    .irq          (irq)
  );

  adma_read_engine u_read_engine (
    .clock        (clock),
    .reset        (reset),
    .go           (rd_go),
    .addr         (rd_addr),
    .words        (rd_words),
    .to_fifo      (rd_to_fifo),
    .arready      (arready),
    .rvalid       (rvalid),
    .rlast        (rlast),
    .rdata        (rdata),
    .rresp        (rresp),
    .araddr       (araddr),
    .arlen        (arlen),
    .arvalid      (arvalid),
    .rready       (rready),
    .busy         (rd_busy),
    .done         (rd_done),
    .error        (rd_error),
    .desc         (desc),
    .fifo_wr      (fifo_wr),
    .fifo_wr_data (fifo_wr_data)
  );

  // busy of the write side is not needed by the sequencer
  adma_write_engine u_write_engine (
    .clock        (clock),
    .reset        (reset),
    .go           (wr_go),
    .addr         (wr_addr),
    .words        (wr_words),
    .card_word    (card_word),
    .awready      (awready),
    .wready       (wready),
    .bvalid       (bvalid),
    .bresp        (bresp),
    .fifo_rd_data (fifo_rd_data),
    .awaddr       (awaddr),
    .awlen        (awlen),
    .awvalid      (awvalid),
    .wvalid       (wvalid),
    .wlast        (wlast),
    .bready       (bready),
    .wdata        (wdata),
    .fifo_rd      (fifo_rd),
    .busy         (),
    .done         (wr_done),
    .error        (wr_error)
  );

endmodule

/* rtl/adma_sequencer.sv */
`timescale 1ns/1ns

module adma_sequencer
  import axi_pkg::*;
  import adma_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        start,
  input  axi_addr_t   desc_pointer,
  input  logic        dir,
  input  logic        int_clear,
  input  logic        xfer_done,
  input  logic        rd_busy,
  input  logic        rd_done,
  input  logic        rd_error,
  input  adma_desc_t  desc,
  input  logic        wr_done,
  input  logic        wr_error,
  output logic        rd_go,
  output axi_addr_t   rd_addr,
  output word_count_t rd_words,
  output logic        rd_to_fifo,
  output logic        wr_go,
  output axi_addr_t   wr_addr,
  output word_count_t wr_words,
  output logic [1:0]  irq
);

  adma_state_t state;
  adma_desc_t  line;
  axi_addr_t   pointer;
  axi_addr_t   next_ptr;
  logic        dir_q;
  logic        active;
  logic        xfer_seen;
  logic [1:0]  act;
  logic [15:0] len_bytes;
  word_count_t tfr_words;
  logic        eng_done;
  logic        eng_error;

  assign act       = line[DESC_ACT_LSB +: 2];
  assign len_bytes = line[DESC_LEN_LSB +: 16];
  // Zero length stands for 65536 bytes
  assign tfr_words = (len_bytes == 16'd0) ? word_count_t'(65536 / BYTES_PER_WORD) :
                     word_count_t'(len_bytes / BYTES_PER_WORD);
  assign next_ptr  = (act == ACT_LINK) ? line[DESC_ADDR_LSB +: 32] :
                     pointer + axi_addr_t'(DESC_STRIDE);
  assign eng_done  = dir_q ? wr_done : rd_done;
  assign eng_error = dir_q ? wr_error : rd_error;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state      <= ST_STOP;
      rd_go      <= 1'b0;
      wr_go      <= 1'b0;
      rd_to_fifo <= 1'b0;
      dir_q      <= 1'b0;
      active     <= 1'b0;
      xfer_seen  <= 1'b0;
      irq        <= '0;
    end else begin
      rd_go <= 1'b0;
      wr_go <= 1'b0;
      // The serializer may finish before the last memory write does
      if (xfer_done) begin
        xfer_seen <= 1'b1;
      end
      case (state)
        ST_STOP: begin
          if (start && !rd_busy) begin
            pointer    <= desc_pointer;
            dir_q      <= dir;
            xfer_seen  <= 1'b0;
            rd_go      <= 1'b1;
            rd_addr    <= desc_pointer;
            rd_words   <= word_count_t'(DESC_WORDS);
            rd_to_fifo <= 1'b0;
            state      <= ST_FDS;
          end
        end
        ST_FDS: begin
          if (rd_done) begin
            line <= desc;
            if (rd_error || !desc[DESC_VALID]) begin
              irq[IRQ_ERR] <= 1'b1;
              state        <= ST_STOP;
            end else begin
              state <= ST_CADR;
            end
          end
        end
        ST_CADR: begin
          pointer <= next_ptr;
          unique case (act)
            ACT_TRAN: state <= ST_TFR;
            ACT_LINK, ACT_NOP, ACT_RSV: begin
              if (line[DESC_END]) begin
                state <= ST_WAIT_XFER;
              end else begin
                rd_go      <= 1'b1;
                rd_addr    <= next_ptr;
                rd_words   <= word_count_t'(DESC_WORDS);
                rd_to_fifo <= 1'b0;
                state      <= ST_FDS;
              end
            end
          endcase
        end
        ST_TFR: begin
          if (!active) begin
            // Launch the engine for this direction
            active <= 1'b1;
            if (dir_q) begin
              wr_go    <= 1'b1;
              wr_addr  <= line[DESC_ADDR_LSB +: 32];
              wr_words <= tfr_words;
            end else begin
              rd_go      <= 1'b1;
              rd_addr    <= line[DESC_ADDR_LSB +: 32];
              rd_words   <= tfr_words;
              rd_to_fifo <= 1'b1;
            end
          end else if (eng_done) begin
            active <= 1'b0;
            if (eng_error) begin
              irq[IRQ_ERR] <= 1'b1;
              state        <= ST_STOP;
            end else if (line[DESC_END]) begin
              state <= ST_WAIT_XFER;
            end else begin
              rd_go      <= 1'b1;
              rd_addr    <= pointer;
              rd_words   <= word_count_t'(DESC_WORDS);
              rd_to_fifo <= 1'b0;
              state      <= ST_FDS;
            end
          end
        end
        ST_WAIT_XFER: begin
          if (xfer_done || xfer_seen) begin
            irq[IRQ_XFER] <= 1'b1;
            state         <= ST_STOP;
          end
        end
        default: state <= ST_STOP;
      endcase
      if (int_clear) begin
        irq <= '0;
      end
    end
  end

endmodule

/* rtl/adma_write_engine.sv */
`timescale 1ns/1ns

module adma_write_engine
  import axi_pkg::*;
  import adma_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        go,
  input  axi_addr_t   addr,
  input  word_count_t words,
  input  logic        card_word,
  input  logic        awready,
  input  logic        wready,
  input  logic        bvalid,
  input  axi_resp_t   bresp,
  input  axi_data_t   fifo_rd_data,
  output axi_addr_t   awaddr,
  output axi_len_t    awlen,
  output logic        awvalid,
  output logic        wvalid,
  output logic        wlast,
  output logic        bready,
  output axi_data_t   wdata,
  output logic        fifo_rd,
  output logic        busy,
  output logic        done,
  output logic        error
);

  localparam axi_addr_t BURST_STEP = axi_addr_t'(MAX_BURST_BEATS * BYTES_PER_WORD);

  typedef enum logic [2:0] {
    WR_IDLE,
    WR_WAIT,
    WR_ADDR,
    WR_DATA,
    WR_RESP
  } wr_phase_t;

  wr_phase_t   phase;
  axi_addr_t   cur_addr;
  word_count_t remaining;
  word_count_t sent;
  word_count_t card_count;
  axi_len_t    beat_idx;
  logic [4:0]  burst_words;
  logic        data_beat;
  logic        resp_beat;
  logic        resp_err;

  assign burst_words = (remaining >= word_count_t'(MAX_BURST_BEATS)) ?
                       5'(MAX_BURST_BEATS) : remaining[4:0];
  assign awaddr      = cur_addr;
  assign awlen       = axi_len_t'(burst_words - 5'd1);
  assign wdata       = fifo_rd_data;
  // Also true on the only beat of a 1-beat burst
  assign wlast       = (beat_idx == awlen);
  assign data_beat   = wvalid && wready;
  assign fifo_rd     = data_beat;
  assign resp_beat   = bvalid && bready;
  assign resp_err    = (bresp == AXI_RESP_SLVERR) || (bresp == AXI_RESP_DECERR);

  always_ff @(posedge clock) begin
    if (!reset) begin
      phase      <= WR_IDLE;
      awvalid    <= 1'b0;
      wvalid     <= 1'b0;
      bready     <= 1'b0;
      busy       <= 1'b0;
      done       <= 1'b0;
      error      <= 1'b0;
      remaining  <= '0;
      sent       <= '0;
      card_count <= '0;
      beat_idx   <= '0;
    end else begin
      done <= 1'b0;
      // Words the card has delivered since go
      if (go) begin
        card_count <= word_count_t'(card_word);
      end else if (card_word) begin
        card_count <= card_count + 1'b1;
      end
      case (phase)
        WR_IDLE: begin
          if (go) begin
            remaining <= words;
            sent      <= '0;
            busy      <= 1'b1;
            error     <= 1'b0;
            phase     <= WR_WAIT;
          end
        end
        WR_WAIT: begin
          if (card_count >= sent + word_count_t'(burst_words)) begin
            awvalid <= 1'b1;
            phase   <= WR_ADDR;
          end
        end
        WR_ADDR: begin
          if (awready) begin
            awvalid  <= 1'b0;
            wvalid   <= 1'b1;
            beat_idx <= '0;
            phase    <= WR_DATA;
          end
        end
        WR_DATA: begin
          if (data_beat) begin
            beat_idx <= beat_idx + 1'b1;
            if (wlast) begin
              wvalid <= 1'b0;
              phase  <= WR_RESP;
            end
          end
        end
        WR_RESP: begin
          if (bvalid && !bready) begin
            bready <= 1'b1;
          end
          if (resp_beat) begin
            bready <= 1'b0;
            if (resp_err) begin
              error <= 1'b1;
              busy  <= 1'b0;
              done  <= 1'b1;
              phase <= WR_IDLE;
            end else begin
              remaining <= remaining - word_count_t'(burst_words);
              sent      <= sent + word_count_t'(burst_words);
              if (remaining == word_count_t'(burst_words)) begin
                busy  <= 1'b0;
                done  <= 1'b1;
                phase <= WR_IDLE;
              end else begin
                phase <= WR_WAIT;
              end
            end
          end
        end
        default: phase <= WR_IDLE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (go) begin
      cur_addr <= addr;
    end else if (phase == WR_RESP && resp_beat) begin
      cur_addr <= cur_addr + BURST_STEP;
    end
  end

endmodule

/* rtl/adma_read_engine.sv */
`timescale 1ns/1ns

module adma_read_engine
  import axi_pkg::*;
  import adma_pkg::*;
(
  input  logic        clock,
  input  logic        reset,
  input  logic        go,
  input  axi_addr_t   addr,
  input  word_count_t words,
  input  logic        to_fifo,
  input  logic        arready,
  input  logic        rvalid,
  input  logic        rlast,
  input  axi_data_t   rdata,
  input  axi_resp_t   rresp,
  output axi_addr_t   araddr,
  output axi_len_t    arlen,
  output logic        arvalid,
  output logic        rready,
  output logic        busy,
  output logic        done,
  output logic        error,
  output adma_desc_t  desc,
  output logic        fifo_wr,
  output axi_data_t   fifo_wr_data
);

  localparam axi_addr_t BURST_STEP = axi_addr_t'(MAX_BURST_BEATS * BYTES_PER_WORD);

  axi_addr_t   cur_addr;
  word_count_t remaining;
  logic        to_fifo_q;
  logic [4:0]  burst_words;
  logic        beat;
  logic        beat_err;

  // Full bursts first, tail burst takes what is left
  assign burst_words = (remaining >= word_count_t'(MAX_BURST_BEATS)) ?
                       5'(MAX_BURST_BEATS) : remaining[4:0];
  assign araddr      = cur_addr;
  assign arlen       = axi_len_t'(burst_words - 5'd1);
  assign beat        = rvalid && rready;
  assign beat_err    = (rresp == AXI_RESP_SLVERR) || (rresp == AXI_RESP_DECERR);

  //////////////////////////////
  // Channel control
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (!reset) begin
      arvalid   <= 1'b0;
      rready    <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      error     <= 1'b0;
      fifo_wr   <= 1'b0;
      to_fifo_q <= 1'b0;
      remaining <= '0;
    end else begin
      done    <= 1'b0;
      fifo_wr <= 1'b0;
      if (go) begin
        remaining <= words;
        to_fifo_q <= to_fifo;
        busy      <= 1'b1;
        arvalid   <= 1'b1;
        error     <= 1'b0;
      end
      // rready stays up for the whole open burst
      if (arvalid && arready) begin
        arvalid <= 1'b0;
        rready  <= 1'b1;
      end
      if (beat) begin
        remaining <= remaining - 1'b1;
        if (beat_err) begin
          error <= 1'b1;
        end else if (to_fifo_q && !error) begin
          fifo_wr <= 1'b1;
        end
        if (rlast) begin
          rready <= 1'b0;
          // An error response cuts the transfer short at the burst end
          if (remaining == word_count_t'(1) || error || beat_err) begin
            busy <= 1'b0;
            done <= 1'b1;
          end else begin
            arvalid <= 1'b1;
          end
        end
      end
    end
  end

  //////////////////////////////
  // Address and data path
  //////////////////////////////
  always_ff @(posedge clock) begin
    if (go) begin
      cur_addr <= addr;
    end else if (beat && rlast) begin
      cur_addr <= cur_addr + BURST_STEP;
    end
    if (beat) begin
      fifo_wr_data <= rdata;
      // first beat ends up in the low half
      if (!to_fifo_q) begin
        desc <= {rdata, desc[63:32]};
      end
    end
  end

endmodule

/* rtl/adma_pkg.sv */
package adma_pkg;

  // One 64-bit ADMA2 descriptor line
  typedef logic [63:0] adma_desc_t;

  // Up to 65536 bytes per line, counted in words
  typedef logic [16:0] word_count_t;

  // Descriptor field positions
  localparam int DESC_VALID    = 0;
  localparam int DESC_END      = 1;
  localparam int DESC_ACT_LSB  = 4;
  localparam int DESC_LEN_LSB  = 16;
  localparam int DESC_ADDR_LSB = 32;

  // act field encodings
  localparam logic [1:0] ACT_NOP  = 2'd0;
  localparam logic [1:0] ACT_RSV  = 2'd1;
  localparam logic [1:0] ACT_TRAN = 2'd2;
  localparam logic [1:0] ACT_LINK = 2'd3;

  // Descriptor fetch is a two-beat burst
  localparam int DESC_WORDS  = 2;
  localparam int DESC_STRIDE = 8;

  typedef enum logic [2:0] {
    ST_STOP,
    ST_FDS,
    ST_CADR,
    ST_TFR,
    ST_WAIT_XFER
  } adma_state_t;

  localparam int IRQ_XFER = 0;
  localparam int IRQ_ERR  = 1;

endpackage

/* rtl/axi_pkg.sv */
package axi_pkg;

  // Bus widths
  typedef logic [31:0] axi_addr_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [7:0]  axi_len_t;
  typedef logic [1:0]  axi_resp_t;

  // Burst encodings
  localparam logic [2:0] AXI_SIZE_WORD  = 3'b010;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  localparam int MAX_BURST_BEATS = 16;
  localparam int BYTES_PER_WORD  = 4;

  // Response codes
  localparam axi_resp_t AXI_RESP_OKAY   = 2'b00;
  localparam axi_resp_t AXI_RESP_EXOKAY = 2'b01;
  localparam axi_resp_t AXI_RESP_SLVERR = 2'b10;
  localparam axi_resp_t AXI_RESP_DECERR = 2'b11;

endpackage
